/* Bender.yml */
package:
  name: kbd_subsystem

sources:
  - hw/kbd_pkg.sv
  - hw/ps2_receiver.sv
  - hw/key_fifo.sv
  - hw/key_port.sv
  - hw/kbd_subsystem.sv
  - target: test
    files:
      - test/kbd_props.sv
      - test/kbd_tb.sv

/* hw/kbd_pkg.sv */
package kbd_pkg;

    // Widths that carry a meaning on the bus and in the key path
    typedef logic [7:0]  scan_code_t;
    typedef logic [31:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;
    typedef logic [3:0]  irq_vec_t;

    // One FIFO word, release flag above the scan code
    typedef struct packed {
        logic       released;
        scan_code_t code;
    } key_event_t;

    // One CPU bus request as seen by the I/O slice
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        logic      we;
        logic      re;
    } bus_req_t;

    // Address map
    localparam bus_addr_t KEY_BASE   = 32'h0000_8000;
    localparam bus_addr_t KEY_STATUS = KEY_BASE + 32'd8;
    localparam bus_addr_t ART_BASE   = 32'h0000_8010;

    // Keyboard interrupt vector
    localparam irq_vec_t KEY_IRQ = 4'd1;

    // Event buffer depth
    localparam int FIFO_DEPTH = 8;

    // PS/2 set 2 break prefix
    localparam scan_code_t BREAK_CODE = 8'hF0;

endpackage

/* hw/kbd_subsystem.sv */
`timescale 1ns/1ps

module kbd_subsystem import kbd_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       PS2_CLK,
    input  logic       PS2_DAT,
    input  bus_req_t   bus_req,
    output bus_data_t  bus_rdata,
    output logic       bus_rvalid,
    output irq_vec_t   irq_vector,
    input  logic       irq_ack,
    output logic       uart_wr,
    output logic [7:0] uart_data
);

    key_event_t rx_event;
    logic       rx_valid;
    logic       frame_err;
    key_event_t head;
    logic       empty;
    logic       full;
    logic       overflow;
    logic       pop;
    logic       ovf_clear;

    ps2_receiver u_rx (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .ps2_clk   (PS2_CLK),
        .ps2_dat   (PS2_DAT),
        .rx_event  (rx_event),
        .rx_valid  (rx_valid),
        .frame_err (frame_err)
    );

    // Full FIFO is the only back-pressure, new events are dropped
    key_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .push      (rx_valid),
        .push_data (rx_event),
        .pop       (pop),
        .ovf_clear (ovf_clear),
        .head      (head),
        .empty     (empty),
        .full      (full),
        .overflow  (overflow)
    );

    key_port u_port (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .bus_req    (bus_req),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .head       (head),
        .empty      (empty),
        .overflow   (overflow),
        .frame_err  (frame_err),
        .pop        (pop),
        .ovf_clear  (ovf_clear),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack),
        .uart_wr    (uart_wr),
        .uart_data  (uart_data)
    );

endmodule

/* hw/key_fifo.sv */
`timescale 1ns/1ps

module key_fifo import kbd_pkg::*; #(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       push,
    input  key_event_t push_data,
    input  logic       pop,
    input  logic       ovf_clear,
    output key_event_t head,
    output logic       empty,
    output logic       full,
    output logic       overflow
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    key_event_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge CLOCK_50) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap explicitly so odd depths work too
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Sticky until the status read, a new drop wins over the clear
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1;
        end else if (ovf_clear) begin
            overflow <= 1'b0;
        end
    end

endmodule

/* hw/key_port.sv */
`timescale 1ns/1ps

module key_port import kbd_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  bus_req_t   bus_req,
    output bus_data_t  bus_rdata,
    output logic       bus_rvalid,
    input  key_event_t head,
    input  logic       empty,
    input  logic       overflow,
    input  logic       frame_err,
    output logic       pop,
    output logic       ovf_clear,
    output irq_vec_t   irq_vector,
    input  logic       irq_ack,
    output logic       uart_wr,
    output logic [7:0] uart_data
);

    logic      rd_key;
    logic      rd_status;
    logic      wr_art;
    logic      wr_art_d;
    logic      frame_err_sticky;
    logic      empty_d;
    bus_data_t rd_word;

    // Address decode
    assign rd_key    = bus_req.re && (bus_req.addr == KEY_BASE);
    assign rd_status = bus_req.re && (bus_req.addr == KEY_STATUS);
    assign wr_art    = bus_req.we && (bus_req.addr == ART_BASE);

    // Data read consumes the head, status read clears the flags
    assign pop       = rd_key & ~empty;
    assign ovf_clear = rd_status;

    always_comb begin
        rd_word = '0;
        if (rd_key && !empty) begin
            // Valid in bit 15, release in bit 8
            rd_word[15]  = 1'b1;
            rd_word[8:0] = head;
        end else if (rd_status) begin
            rd_word[2:0] = {frame_err_sticky, overflow, ~empty};
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus_req.re) begin
            bus_rdata <= rd_word;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_rvalid <= 1'b0;
        end else begin
            bus_rvalid <= bus_req.re;
        end
    end

    // Frame errors held until status is read
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            frame_err_sticky <= 1'b0;
        end else if (frame_err) begin
            frame_err_sticky <= 1'b1;
        end else if (rd_status) begin
            frame_err_sticky <= 1'b0;
        end
    end

    // Console write, one strobe per rising write enable
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wr_art_d <= 1'b0;
            uart_wr  <= 1'b0;
        end else begin
            wr_art_d <= wr_art;
            uart_wr  <= wr_art & ~wr_art_d;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (wr_art && !wr_art_d) begin
            uart_data <= bus_req.wdata[7:0];
        end
    end

    // Interrupt raised on empty to non-empty, dropped on ack
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            empty_d    <= 1'b1;
            irq_vector <= '0;
        end else begin
            empty_d <= empty;
            if (irq_vector != '0 && irq_ack) begin
                irq_vector <= '0;
            end
            if (empty_d && !empty) begin
                irq_vector <= KEY_IRQ;
            end
        end
    end

endmodule

/* hw/ps2_receiver.sv */
`timescale 1ns/1ps

module ps2_receiver import kbd_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output key_event_t rx_event,
    output logic       rx_valid,
    output logic       frame_err
);

    logic [1:0]  clk_sync;
    logic [1:0]  dat_sync;
    logic        clk_prev;
    logic        fall;
    logic [10:0] frame;
    logic [3:0]  bit_cnt;
    logic        frame_done;
    logic        pending_rel;
    scan_code_t  rx_code;
    logic        frame_ok;

    // Two-flop synchronizers, idle level of both lines is high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Device changes data on rising edge, so sample on falling edge
    assign fall = clk_prev & ~clk_sync[1];

    // Bit counter over start, 8 data, parity and stop
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (fall) begin
                if (bit_cnt == 4'd10) begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge CLOCK_50) begin
        if (fall) begin
            frame <= {dat_sync[1], frame[10:1]};
        end
    end

    assign rx_code = frame[8:1];

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    // Event and error strobes, break prefix folded into a flag
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rx_valid    <= 1'b0;
            frame_err   <= 1'b0;
            pending_rel <= 1'b0;
        end else begin
            rx_valid  <= 1'b0;
            frame_err <= 1'b0;
            if (frame_done) begin
                if (!frame_ok) begin
                    frame_err <= 1'b1;
                end else if (rx_code == BREAK_CODE) begin
                    pending_rel <= 1'b1;
                end else begin
                    rx_valid    <= 1'b1;
                    pending_rel <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (frame_done && frame_ok && rx_code != BREAK_CODE) begin
            rx_event <= '{released: pending_rel, code: rx_code};
        end
    end

endmodule

/* tb.f */
hw/kbd_pkg.sv
hw/ps2_receiver.sv
hw/key_fifo.sv
hw/key_port.sv
hw/kbd_subsystem.sv
test/kbd_props.sv
test/kbd_tb.sv

/* test/kbd_props.sv */
`timescale 1ns/1ps

module kbd_props import kbd_pkg::*; (
    input logic     CLOCK_50,
    input logic     KEY0,
    input logic     re,
    input logic     rvalid,
    input logic     uart_wr,
    input logic     full,
    input logic     empty,
    input irq_vec_t irq_vector
);

    // Registered read answers in the next cycle and only then
    a_rvalid_after_re: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        re |=> rvalid)
        else $error("bus_rvalid missing after a read enable");

    a_rvalid_needs_re: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        rvalid |-> $past(re))
        else $error("bus_rvalid without a read enable the cycle before");

    a_uart_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        uart_wr |=> !uart_wr)
        else $error("uart_wr high for two cycles");

    a_fifo_flags: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(full && empty))
        else $error("FIFO full and empty together");

    // Only the keyboard vector exists in this slice
    a_irq_values: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        irq_vector == '0 || irq_vector == KEY_IRQ)
        else $error("irq_vector holds an unknown vector");

endmodule

// Key port and FIFO signals meet in the subsystem
bind kbd_subsystem kbd_props u_props (
    .CLOCK_50   (CLOCK_50),
    .KEY0       (KEY0),
    .re         (bus_req.re),
    .rvalid     (bus_rvalid),
    .uart_wr    (uart_wr),
    .full       (full),
    .empty      (empty),
    .irq_vector (irq_vector)
);

/* test/kbd_stim.txt */
# S code good | R addr expect | W addr data strobes byte | A ack | I irq | T name
# values in hex, reads expect valid in bit 15 and release in bit 8
T press_release
S 1C 1
I 1
S F0 1
S 1C 1
R 8000 801C
R 8000 811C
R 8000 0
A
I 0
T bad_parity
S 2A 0
R 8008 4
R 8008 0
I 0
T overflow
S 15 1
S 1D 1
S 24 1
S 2D 1
S 2C 1
S 35 1
S 3C 1
S 43 1
S 44 1
R 8000 8015
R 8000 801D
R 8000 8024
R 8000 802D
R 8000 802C
R 8000 8035
R 8000 803C
R 8000 8043
R 8008 2
R 8000 0
R 8008 0
A
I 0
T interrupt
S 1B 1
I 1
A
I 0
S 23 1
I 0
R 8000 801B
R 8000 8023
I 0
S 34 1
I 1
A
I 0
R 8000 8034
T console_write
W 8010 1234ABCD 1 CD
W 8000 55 0 0
W 8018 77 0 0
T unmapped_read
R 8040 0
R 8004 0
R 0 0

/* test/kbd_tb.sv */
`timescale 1ns/1ps

module kbd_tb import kbd_pkg::*; ();

    // One parsed line of the stimulus file
    typedef struct packed {
        logic [7:0] op;
        bus_addr_t  a;
        bus_data_t  b;
        logic [3:0] n;
        scan_code_t c;
    } stim_op_t;

    logic       CLOCK_50;
    logic       KEY0;
    logic       ps2_clk;
    logic       ps2_dat;
    bus_req_t   bus_req;
    bus_data_t  bus_rdata;
    logic       bus_rvalid;
    irq_vec_t   irq_vector;
    logic       irq_ack;
    logic       uart_wr;
    logic [7:0] uart_data;

    stim_op_t ops[$];
    string    names[$];
    string    test_name;
    int       frames = 0;
    int       limit = 0;
    int       cycles = 0;
    int       checks = 0;
    int       errors = 0;
    int       test_errs = 0;
    int       test_num = 0;

    kbd_subsystem DUT (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .PS2_CLK    (ps2_clk),
        .PS2_DAT    (ps2_dat),
        .bus_req    (bus_req),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid),
        .irq_vector (irq_vector),
        .irq_ack    (irq_ack),
        .uart_wr    (uart_wr),
        .uart_data  (uart_data)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #10 CLOCK_50 = ~CLOCK_50;
    end

    // Watchdog, limit comes from the stimulus length
    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("run stopped after %0d cycles, the stimulus did not finish", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic load_stim();
        int         fd;
        string      line;
        string      nm;
        stim_op_t   rec;
        logic [7:0] op;
        bus_addr_t  a;
        bus_data_t  b;
        logic [3:0] n;
        scan_code_t c;
        fd = $fopen("test/kbd_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/kbd_stim.txt");
            $display("tests failed");
            $finish;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            a = '0;
            b = '0;
            n = '0;
            c = '0;
            if (line[0] == "T") begin
                void'($sscanf(line, "%c %s", op, nm));
                names.push_back(nm);
            end else begin
                void'($sscanf(line, "%c %h %h %h %h", op, a, b, n, c));
            end
            rec = '{op: op, a: a, b: b, n: n, c: c};
            if (op == "S") begin
                frames++;
            end
            ops.push_back(rec);
        end
        $fclose(fd);
    endtask

    task automatic count_failure(input string msg);
        checks++;
        errors++;
        test_errs++;
        $display("%s (at %0d ns)", msg, $time);
    endtask

    task automatic check_rdata(input bus_data_t got, input bus_data_t exp, input bus_addr_t addr);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("Fail at %0d ns: read of 0x%h gave 0x%h, expected 0x%h",
                     $time, addr, got, exp);
        end
    endtask

    task automatic check_irq(input irq_vec_t got, input irq_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("Fail at %0d ns: irq_vector is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_uart(input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("Fail at %0d ns: uart_data is 0x%h, expected 0x%h", $time, got, exp);
        end
    endtask

    // Device side of PS/2, half bit is 10 system cycles
    task automatic send_frame(input scan_code_t code, input logic good);
        logic [10:0] bits;
        logic        parity;
        logic        seen;
        parity = ~^code;
        if (!good) begin
            parity = ~parity;
        end
        bits = {1'b1, parity, code, 1'b0};
        seen = 1'b0;
        for (int i = 0; i < 11; i++) begin
            ps2_dat = bits[i];
            repeat (10) @(negedge CLOCK_50);
            ps2_clk = 1'b0;
            for (int j = 0; j < 10; j++) begin
                @(negedge CLOCK_50);
                if (i == 10 && DUT.u_rx.frame_done) begin
                    seen = 1'b1;
                end
            end
            ps2_clk = 1'b1;
        end
        if (!seen) begin
            count_failure($sformatf("receiver never finished the frame for 0x%h", code));
        end
        repeat (4 + $urandom % 16) @(negedge CLOCK_50);
    endtask

    task automatic bus_read(input bus_addr_t addr, input bus_data_t exp);
        bus_req.addr = addr;
        bus_req.re   = 1'b1;
        @(negedge CLOCK_50);
        bus_req.re = 1'b0;
        if (!bus_rvalid) begin
            count_failure($sformatf("no bus_rvalid one cycle after the read of 0x%h", addr));
        end else begin
            check_rdata(bus_rdata, exp, addr);
        end
    endtask

    // Write enable held for three cycles
    task automatic bus_write(input bus_addr_t addr, input bus_data_t data,
                             input logic [3:0] exp_n, input logic [7:0] exp_byte);
        int         strobes;
        logic [7:0] got;
        strobes = 0;
        got = '0;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        bus_req.we    = 1'b1;
        for (int i = 0; i < 5; i++) begin
            @(negedge CLOCK_50);
            if (i == 2) begin
                bus_req.we = 1'b0;
            end
            if (uart_wr) begin
                strobes++;
                got = uart_data;
            end
        end
        if (strobes != exp_n) begin
            count_failure($sformatf("write to 0x%h gave %0d uart_wr strobes instead of %0d",
                                    addr, strobes, exp_n));
        end else if (exp_n != 0) begin
            check_uart(got, exp_byte);
        end
    endtask

    task automatic send_ack();
        irq_ack = 1'b1;
        @(negedge CLOCK_50);
        irq_ack = 1'b0;
    endtask

    task automatic finish_test();
        if (test_num > 0) begin
            $display("test %0d %s: %0d errors", test_num, test_name, test_errs);
        end
    endtask

    task automatic run_op(input stim_op_t rec);
        case (rec.op)
            "T": begin
                finish_test();
                test_num++;
                test_name = names[test_num - 1];
                test_errs = 0;
            end
            "S": send_frame(rec.a[7:0], rec.b[0]);
            "R": bus_read(rec.a, rec.b);
            "W": bus_write(rec.a, rec.b, rec.n, rec.c);
            "A": send_ack();
            "I": check_irq(irq_vector, rec.a[3:0]);
            default: count_failure($sformatf("unknown operation '%c' in the stimulus", rec.op));
        endcase
    endtask

    initial begin
        KEY0    = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        bus_req = '0;
        irq_ack = 1'b0;
        void'($urandom(32'h241ed36c));
        load_stim();
        limit = frames * 300 + (ops.size() - frames) * 20 + 200;
        repeat (8) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);
        foreach (ops[k]) begin
            run_op(ops[k]);
        end
        finish_test();
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
